// File: logic/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// address and data widths.
`define ADDR_W      32
`define DATA_W      64
`define LINE_W      128

// cache geometry.
`define OFFSET_W    4
`define INDEX_W     6
`define TAG_W       22
`define WAYS        4

// first address of the uncached device region.
`define DEVICE_BASE 32'h9000_0000

// backing memory depth in lines, log2.
`define MEM_LINES_W 12

`endif

// File: logic/mem_types_pkg.sv
`include "dcache_consts.svh"

package mem_types_pkg;

	////////////////////
	// memory side types
	////////////////////

	// byte address.
	typedef logic [`ADDR_W-1:0] addr_t;

	// one data word.
	typedef logic [`DATA_W-1:0] data_t;

	// per-bit write mask, 1 writes the bit.
	typedef logic [`DATA_W-1:0] mask_t;

	// two words, low word at address bit 3 clear.
	typedef logic [`LINE_W-1:0] line_t;

endpackage

// File: logic/cache_types_pkg.sv
`include "dcache_consts.svh"

package cache_types_pkg;

	////////////////////
	// cache organization
	////////////////////

	// upper address bits kept per line.
	typedef logic [`TAG_W-1:0] tag_t;

	// set select, address bits 9..4.
	typedef logic [`INDEX_W-1:0] index_t;

	// one bit per way.
	// used for hit vectors, allocation and the replacement pointer.
	typedef logic [`WAYS-1:0] way_mask_t;

endpackage

// File: logic/line_sram.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module line_sram
	import mem_types_pkg::*;
	import cache_types_pkg::*;
(
	input  logic   clk,
	input  logic   en,
	input  logic   we,
	input  line_t  bit_we,
	input  index_t index,
	input  line_t  wdata,
	output line_t  rdata
);

	localparam int DEPTH = 1 << `INDEX_W;

	line_t mem [DEPTH];

	// single port, read data held between reads.
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= (mem[index] & ~bit_we) | (wdata & bit_we);
			end else begin
				rdata <= mem[index];
			end
		end
	end

	// enable is always driven known.
	a_en_known: assert property (@(posedge clk) !$isunknown(en))
		else $error("line_sram: en went unknown");

endmodule

// File: logic/dcache_tag_store.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tag_store
	import cache_types_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  index_t    index,
	input  tag_t      tag,
	output way_mask_t way_hit,
	input  way_mask_t alloc
);

	localparam int SETS = 1 << `INDEX_W;

	way_mask_t valid_q [SETS];
	tag_t      tags [`WAYS][SETS];

	////////////////////
	// lookup
	////////////////////

	// all ways compared in parallel.
	always_comb begin
		for (int w = 0; w < `WAYS; w++) begin
			way_hit[w] = valid_q[index][w] && tags[w][index] == tag;
		end
	end

	////////////////////
	// allocation
	////////////////////

	// valid bits, cleared on reset.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < SETS; s++) begin
				valid_q[s] <= '0;
			end
		end else if (|alloc) begin
			valid_q[index] <= valid_q[index] | alloc;
		end
	end

	// tag written into the allocated way.
	always_ff @(posedge clk) begin
		for (int w = 0; w < `WAYS; w++) begin
			if (alloc[w]) begin
				tags[w][index] <= tag;
			end
		end
	end

	// a tag never lives in two ways of one set.
	a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit))
		else $error("dcache_tag_store: multiple ways hit");

	// controller allocates at most one way per request.
	a_alloc_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(alloc))
		else $error("dcache_tag_store: alloc not one-hot");

endmodule

// File: logic/dcache.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache
	import mem_types_pkg::*;
	import cache_types_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  valid,
	input  addr_t addr,
	input  logic  wren,
	input  data_t din,
	input  mask_t mask,
	output logic  ready,
	output data_t dout,
	output logic  hit,
	input  line_t rline,
	output logic  mem_we
);

	// address bit picking the word within a line.
	localparam int HALF_BIT = `OFFSET_W - 1;

	logic      req;
	logic      cacheable;
	index_t    index;
	tag_t      tag;
	way_mask_t way_hit;
	logic      any_hit;
	way_mask_t repl_ptr;
	way_mask_t alloc;
	way_mask_t sram_en;
	logic      sram_we;
	line_t     sram_bit_we;
	line_t     sram_wdata;
	line_t     sram_rdata [`WAYS];
	data_t     old_word;
	data_t     merged_word;
	line_t     merged_line;
	line_t     saved_line;
	way_mask_t resp_way;
	line_t     resp_line;

	assign req       = valid && !ready;
	assign cacheable = addr < `DEVICE_BASE;
	assign index     = addr[`OFFSET_W +: `INDEX_W];
	assign tag       = addr[`ADDR_W-1 -: `TAG_W];
	assign any_hit   = |way_hit;

	// every store goes through to memory.
	assign mem_we = req && wren;

	////////////////////
	// line merge
	////////////////////

	assign old_word    = addr[HALF_BIT] ? rline[`LINE_W-1 -: `DATA_W] : rline[`DATA_W-1:0];
	assign merged_word = (old_word & ~mask) | (din & mask);

	always_comb begin
		merged_line = rline;
		if (wren) begin
			if (addr[HALF_BIT]) begin
				merged_line[`LINE_W-1 -: `DATA_W] = merged_word;
			end else begin
				merged_line[`DATA_W-1:0] = merged_word;
			end
		end
	end

	////////////////////
	// lookup and sram control
	////////////////////

	dcache_tag_store i_tags (
		.clk     (clk),
		.rst     (rst),
		.index   (index),
		.tag     (tag),
		.way_hit (way_hit),
		.alloc   (alloc)
	);

	// misses fill the way under the pointer.
	assign alloc   = (req && cacheable && !any_hit) ? repl_ptr : '0;
	assign sram_en = (req && cacheable) ? (any_hit ? way_hit : repl_ptr) : '0;
	assign sram_we = wren || !any_hit;

	always_comb begin
		if (!any_hit) begin
			sram_bit_we = '1;
			sram_wdata  = merged_line;
		end else begin
			sram_bit_we = '0;
			if (wren) begin
				sram_bit_we = addr[HALF_BIT] ? {mask, {`DATA_W{1'b0}}} : {{`DATA_W{1'b0}}, mask};
			end
			sram_wdata = {din, din};
		end
	end

	for (genvar w = 0; w < `WAYS; w++) begin : g_way
		line_sram i_sram (
			.clk    (clk),
			.en     (sram_en[w]),
			.we     (sram_we),
			.bit_we (sram_bit_we),
			.index  (index),
			.wdata  (sram_wdata),
			.rdata  (sram_rdata[w])
		);
	end

	////////////////////
	// response
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			ready    <= 1'b0;
			hit      <= 1'b0;
			resp_way <= '0;
			repl_ptr <= way_mask_t'(1);
		end else begin
			ready <= req;
			if (req) begin
				hit      <= cacheable && any_hit;
				resp_way <= (cacheable && !wren) ? way_hit : '0;
				// rotate on every request, device ones too.
				repl_ptr <= {repl_ptr[`WAYS-2:0], repl_ptr[`WAYS-1]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			saved_line <= merged_line;
		end
	end

	// load hits read the sram, everything else the saved line.
	always_comb begin
		resp_line = saved_line;
		for (int w = 0; w < `WAYS; w++) begin
			if (resp_way[w]) begin
				resp_line = sram_rdata[w];
			end
		end
	end

	assign dout = addr[HALF_BIT] ? resp_line[`LINE_W-1 -: `DATA_W] : resp_line[`DATA_W-1:0];

	a_ready_pulse: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
		else $error("dcache: ready held for two cycles");

endmodule

// File: logic/backing_mem.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module backing_mem
	import mem_types_pkg::*;
(
	input  logic  clk,
	input  logic  we,
	input  addr_t addr,
	input  data_t wdata,
	input  mask_t mask,
	output line_t rline
);

	localparam int HALF_BIT = `OFFSET_W - 1;
	localparam int DEPTH    = 1 << `MEM_LINES_W;

	line_t mem [DEPTH];

	logic [`MEM_LINES_W-1:0] line_idx;
	data_t                   old_word;
	data_t                   new_word;

	// upper address bits alias onto the same lines.
	assign line_idx = addr[`OFFSET_W +: `MEM_LINES_W];

	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// asynchronous line read.
	assign rline = mem[line_idx];

	assign old_word = addr[HALF_BIT] ? rline[`LINE_W-1 -: `DATA_W] : rline[`DATA_W-1:0];
	assign new_word = (old_word & ~mask) | (wdata & mask);

	// masked word write into one half.
	always_ff @(posedge clk) begin
		if (we) begin
			if (addr[HALF_BIT]) begin
				mem[line_idx][`LINE_W-1 -: `DATA_W] <= new_word;
			end else begin
				mem[line_idx][`DATA_W-1:0] <= new_word;
			end
		end
	end

endmodule

// File: logic/dcache_subsys.sv
`timescale 1ns/1ps

module dcache_subsys
	import mem_types_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  valid,
	input  addr_t addr,
	input  logic  wren,
	input  data_t din,
	input  mask_t mask,
	output logic  ready,
	output data_t dout,
	output logic  hit
);

	line_t rline;
	logic  mem_we;

	// cache in front of the write-through memory.
	dcache i_dcache (
		.clk    (clk),
		.rst    (rst),
		.valid  (valid),
		.addr   (addr),
		.wren   (wren),
		.din    (din),
		.mask   (mask),
		.ready  (ready),
		.dout   (dout),
		.hit    (hit),
		.rline  (rline),
		.mem_we (mem_we)
	);

	backing_mem i_mem (
		.clk   (clk),
		.we    (mem_we),
		.addr  (addr),
		.wdata (din),
		.mask  (mask),
		.rline (rline)
	);

endmodule

// File: tests/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tb
	import mem_types_pkg::*;
	import cache_types_pkg::*;
();

	localparam int READY_TIMEOUT = 8;
	localparam int RANDOM_REQS   = 2000;
	localparam int HALF_BIT      = `OFFSET_W - 1;
	localparam int SETS          = 1 << `INDEX_W;

	logic  clk;
	logic  rst;
	logic  valid;
	addr_t addr;
	logic  wren;
	data_t din;
	mask_t mask;
	logic  ready;
	data_t dout;
	logic  hit;

	int checks;
	int value_errs;
	int other_errs;

	// reference model state.
	line_t      ref_mem [1 << `MEM_LINES_W];
	logic       ref_valid [SETS][`WAYS];
	tag_t       ref_tag [SETS][`WAYS];
	line_t      ref_line [SETS][`WAYS];
	logic [1:0] ref_ptr;

	// expected responses, oldest first.
	data_t exp_dout_q [$];
	logic  exp_hit_q [$];
	logic  exp_read_q [$];
	data_t cmp_dout;
	logic  cmp_hit;
	logic  cmp_read;

	dcache_subsys i_dut (
		.clk   (clk),
		.rst   (rst),
		.valid (valid),
		.addr  (addr),
		.wren  (wren),
		.din   (din),
		.mask  (mask),
		.ready (ready),
		.dout  (dout),
		.hit   (hit)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////
	// reference model
	////////////////////

	function automatic data_t word_of(input line_t ln, input logic upper);
		return upper ? ln[`LINE_W-1 -: `DATA_W] : ln[`DATA_W-1:0];
	endfunction

	function automatic line_t put_word(input line_t ln, input logic upper, input data_t w);
		line_t r;
		r = ln;
		if (upper) begin
			r[`LINE_W-1 -: `DATA_W] = w;
		end else begin
			r[`DATA_W-1:0] = w;
		end
		return r;
	endfunction

	// updates the model and gives the expected response of one request.
	function automatic void predict_access(input addr_t a, input logic w, input data_t d,
			input mask_t m, output data_t exp_dout, output logic exp_hit);
		index_t                  idx;
		tag_t                    tg;
		logic [`MEM_LINES_W-1:0] mi;
		logic                    upper;
		line_t                   mem_line;
		data_t                   word;
		logic                    found;
		logic [1:0]              sel;

		idx      = a[`OFFSET_W +: `INDEX_W];
		tg       = a[`ADDR_W-1 -: `TAG_W];
		mi       = a[`OFFSET_W +: `MEM_LINES_W];
		upper    = a[HALF_BIT];
		mem_line = ref_mem[mi];
		if (w) begin
			word        = word_of(mem_line, upper);
			mem_line    = put_word(mem_line, upper, (word & ~m) | (d & m));
			ref_mem[mi] = mem_line;
		end
		exp_dout = word_of(mem_line, upper);
		exp_hit  = 1'b0;
		if (a < `DEVICE_BASE) begin
			found = 1'b0;
			sel   = 2'd0;
			for (int i = 0; i < `WAYS; i++) begin
				if (ref_valid[idx][i] && ref_tag[idx][i] == tg) begin
					found = 1'b1;
					sel   = 2'(i);
				end
			end
			if (found) begin
				exp_hit = 1'b1;
				word    = word_of(ref_line[idx][sel], upper);
				if (w) begin
					ref_line[idx][sel] = put_word(ref_line[idx][sel], upper, (word & ~m) | (d & m));
				end else begin
					exp_dout = word;
				end
			end else begin
				ref_valid[idx][ref_ptr] = 1'b1;
				ref_tag[idx][ref_ptr]   = tg;
				ref_line[idx][ref_ptr]  = mem_line;
			end
		end
		// pointer moves on device requests too.
		ref_ptr = ref_ptr + 2'd1;
	endfunction

	task automatic clear_model();
		for (int i = 0; i < (1 << `MEM_LINES_W); i++) begin
			ref_mem[i] = '0;
		end
		for (int s = 0; s < SETS; s++) begin
			for (int w = 0; w < `WAYS; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_tag[s][w]   = '0;
				ref_line[s][w]  = '0;
			end
		end
		ref_ptr = 2'd0;
	endtask

	////////////////////
	// checking
	////////////////////

	task automatic check_value(input string name, input data_t got, input data_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED at %0t: %s got %h, expected %h", $time, name, got, exp);
			value_errs++;
		end
	endtask

	task automatic finish_run();
		$display("checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	endtask

	// responses are compared on the falling edge, where they are stable.
	always @(negedge clk) begin
		if (!rst && ready) begin
			if (exp_hit_q.size() == 0) begin
				$display("ready pulsed at %0t with no request outstanding", $time);
				other_errs++;
			end else begin
				cmp_dout = exp_dout_q.pop_front();
				cmp_hit  = exp_hit_q.pop_front();
				cmp_read = exp_read_q.pop_front();
				check_value("hit", 64'(hit), 64'(cmp_hit));
				if (cmp_read) begin
					check_value("dout", dout, cmp_dout);
				end
			end
		end
	end

	////////////////////
	// stimulus
	////////////////////

	task automatic do_request(input addr_t a, input logic w, input data_t d, input mask_t m);
		data_t e_dout;
		logic  e_hit;
		int    cycles;

		@(posedge clk);
		valid <= 1'b1;
		addr  <= a;
		wren  <= w;
		din   <= d;
		mask  <= m;
		predict_access(a, w, d, m, e_dout, e_hit);
		exp_dout_q.push_back(e_dout);
		exp_hit_q.push_back(e_hit);
		exp_read_q.push_back(!w);
		// first falling edge is still in the request cycle.
		@(negedge clk);
		cycles = 0;
		while (!ready && cycles < READY_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!ready) begin
			$display("timeout at %0t: no ready within %0d cycles of request to %h",
				$time, READY_TIMEOUT, a);
			other_errs++;
			finish_run();
		end else begin
			check_value("latency", 64'(cycles), 64'd1);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			valid <= 1'b0;
		end
	endtask

	// a few sets, two aliasing tag groups, some device traffic.
	function automatic addr_t random_addr();
		addr_t a;
		a                        = '0;
		a[HALF_BIT]              = 1'($urandom_range(0, 1));
		a[`OFFSET_W +: `INDEX_W] = index_t'(3 + 21 * $urandom_range(0, 2));
		a[12:10]                 = 3'($urandom_range(0, 7));
		a[16]                    = 1'($urandom_range(0, 1));
		if ($urandom_range(0, 4) == 0) begin
			a[31:28] = 4'h9;
		end
		return a;
	endfunction

	function automatic mask_t random_mask();
		case ($urandom_range(0, 3))
			0: return '1;
			1: return 64'h0000_0000_ffff_ffff;
			2: return 64'hff00_0000_0000_00ff;
			default: return {$urandom, $urandom};
		endcase
	endfunction

	initial begin
		valid      = 1'b0;
		addr       = '0;
		wren       = 1'b0;
		din        = '0;
		mask       = '0;
		rst        = 1'b1;
		checks     = 0;
		value_errs = 0;
		other_errs = 0;
		void'($urandom(32'hf963_d4c2));
		clear_model();
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		// fresh reads miss with zero, then hit.
		do_request(32'h0000_0100, 1'b0, '0, '0);
		do_request(32'h0000_0108, 1'b0, '0, '0);
		do_request(32'h0000_0100, 1'b0, '0, '0);
		idle(3);

		// full-mask write on a miss, then on a hit.
		do_request(32'h0000_0208, 1'b1, 64'h0123_4567_89ab_cdef, '1);
		do_request(32'h0000_0208, 1'b0, '0, '0);
		do_request(32'h0000_0208, 1'b1, 64'hfeed_face_cafe_f00d, '1);
		do_request(32'h0000_0208, 1'b0, '0, '0);
		idle(2);

		// partial masks on both halves, then seen through the device alias.
		do_request(32'h0000_0300, 1'b1, 64'h1111_2222_3333_4444, '1);
		do_request(32'h0000_0300, 1'b1, 64'haaaa_bbbb_cccc_dddd, 64'h0000_ffff_0000_ffff);
		do_request(32'h0000_0308, 1'b1, 64'h5555_6666_7777_8888, 64'hff00_ff00_ff00_ff00);
		do_request(32'h0000_0300, 1'b0, '0, '0);
		do_request(32'h0000_0308, 1'b0, '0, '0);
		do_request(32'h9000_0300, 1'b0, '0, '0);
		do_request(32'h9000_0308, 1'b0, '0, '0);
		idle(2);

		// five tags in one set force an eviction.
		for (int k = 0; k < 5; k++) begin
			do_request(addr_t'(32'h40 + k * 32'h400), 1'b1, {32'hc0de_0000, 32'(k)}, '1);
		end
		for (int r = 0; r < 2; r++) begin
			for (int k = 0; k < 5; k++) begin
				do_request(addr_t'(32'h40 + k * 32'h400), 1'b0, '0, '0);
			end
		end
		idle(2);

		// device region against aliasing cached lines.
		do_request(32'h0001_0500, 1'b1, 64'h0bad_beef_0bad_beef, '1);
		do_request(32'h9000_0500, 1'b0, '0, '0);
		do_request(32'h9000_0500, 1'b0, '0, '0);
		do_request(32'h9000_0508, 1'b1, 64'h7777_0000_7777_0000, 64'hffff_ffff_0000_0000);
		do_request(32'h9000_0508, 1'b0, '0, '0);
		do_request(32'h0000_0508, 1'b0, '0, '0);
		do_request(32'h0001_0508, 1'b0, '0, '0);
		idle(2);

		// random mix, half of it back to back.
		for (int n = 0; n < RANDOM_REQS; n++) begin
			do_request(random_addr(), 1'($urandom_range(0, 1)), {$urandom, $urandom},
				random_mask());
			if ($urandom_range(0, 1) == 0) begin
				idle(1 + int'($urandom_range(0, 2)));
			end
		end
		idle(2);

		if (exp_hit_q.size() != 0) begin
			$display("%0d responses never arrived", exp_hit_q.size());
			other_errs++;
		end
		finish_run();
	end

endmodule

// File: sources.f
+incdir+logic
logic/mem_types_pkg.sv
logic/cache_types_pkg.sv
logic/line_sram.sv
logic/dcache_tag_store.sv
logic/dcache.sv
logic/backing_mem.sv
logic/dcache_subsys.sv
tests/dcache_tb.sv

// File: run.sh
#!/bin/sh
# compile and run, then look for the fail message in the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module dcache_tb -f sources.f -o dcache_sim \
	&& ./obj_dir/dcache_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qF '** FAIL **' sim.log && exit 1
grep -qF '** PASS **' sim.log || exit 1
exit 0
